// File: Bender.yml
package:
  name: movement_top

sources:
  # Packages come first, the RTL refers to them by scope.
  - hdl/display_pkg.sv
  - hdl/game_pkg.sv
  - hdl/step_timer.sv
  - hdl/terrain_lookup.sv
  - hdl/character_motion.sv
  - hdl/movement_top.sv
  - target: simulation
    files:
      - verification/movement_top_tb.sv

// File: hdl/character_motion.sv
`timescale 1ns/1ps

module character_motion (
    input  logic              clk,
    input  logic              rst,
    input  logic              left,
    input  logic              right,
    input  logic              jump,
    input  logic              up,
    input  logic              down,
    input  logic              start_game,
    input  logic              animation,
    input  logic              move_tick,
    input  logic              fall_tick,
    input  logic              ladder,
    input  game_pkg::ramp_t   ramp,
    input  display_pkg::pos_t climb_min,
    input  display_pkg::pos_t climb_max,
    input  logic              end_of_platform,
    input  display_pkg::pos_t landing_y,
    output logic              restart,
    output display_pkg::pos_t xpos,
    output display_pkg::pos_t ypos
);

    typedef enum logic [2:0] {
        IDLE,
        LADDER_IDLE,
        WALK_LEFT,
        WALK_RIGHT,
        JUMP,
        FALL,
        CLIMB_UP,
        CLIMB_DOWN
    } state_t;

    state_t            state;
    state_t            state_nxt;
    display_pkg::pos_t xpos_nxt;
    display_pkg::pos_t ypos_nxt;
    display_pkg::pos_t save_y;
    display_pkg::pos_t save_y_nxt;
    display_pkg::pos_t velocity;
    display_pkg::pos_t velocity_nxt;
    display_pkg::pos_t peak_y;
    logic              done;
    logic              done_nxt;
    logic              keys_on;
    logic              on_step;
    logic              can_go_left;
    logic              can_go_right;

    // Keys are ignored before the game starts and while an animation plays.
    assign keys_on = start_game && !animation;

    assign peak_y  = save_y - game_pkg::JUMP_HEIGHT;
    assign on_step = (xpos % game_pkg::RAMP_STEP_X) == '0;

    assign can_go_left  = xpos > 12'd1;
    assign can_go_right = (xpos + game_pkg::CHARACTER_WIDTH) < display_pkg::HOR_PIXELS;

    // Pacing restarts whenever the FSM waits for a key.
    assign restart = (state == IDLE) || (state == LADDER_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            xpos     <= game_pkg::START_X;
            ypos     <= game_pkg::GROUND_Y;
            velocity <= '0;
            done     <= 1'b0;
        end else begin
            state    <= state_nxt;
            xpos     <= xpos_nxt;
            ypos     <= ypos_nxt;
            velocity <= velocity_nxt;
            done     <= done_nxt;
        end
    end

    always_ff @(posedge clk) begin
        save_y <= save_y_nxt;
    end

    always_comb begin
        state_nxt    = state;
        xpos_nxt     = xpos;
        ypos_nxt     = ypos;
        save_y_nxt   = save_y;
        velocity_nxt = velocity;
        done_nxt     = done;

        case (state)
            IDLE: begin
                save_y_nxt   = ypos;
                velocity_nxt = '0;
                done_nxt     = 1'b0;
                if (end_of_platform) begin
                    save_y_nxt = landing_y;
                    state_nxt  = FALL;
                end else if (keys_on && left) begin
                    state_nxt = WALK_LEFT;
                end else if (keys_on && right) begin
                    state_nxt = WALK_RIGHT;
                end else if (keys_on && jump) begin
                    state_nxt = JUMP;
                end else if (keys_on && up && ladder) begin
                    state_nxt = CLIMB_UP;
                end else if (keys_on && down && ladder) begin
                    state_nxt = CLIMB_DOWN;
                end
            end

            LADDER_IDLE: begin
                if (done) begin
                    state_nxt = IDLE;
                end else if (keys_on && up) begin
                    state_nxt = CLIMB_UP;
                end else if (keys_on && down) begin
                    state_nxt = CLIMB_DOWN;
                end
            end

            WALK_LEFT: begin
                if (move_tick) begin
                    state_nxt = IDLE;
                    if (can_go_left) begin
                        xpos_nxt = xpos - 12'd1;
                        if (on_step && ramp == game_pkg::RAMP_RISE) begin
                            ypos_nxt = ypos + game_pkg::RAMP_STEP_Y;
                        end else if (on_step && ramp == game_pkg::RAMP_FALL) begin
                            ypos_nxt = ypos - game_pkg::RAMP_STEP_Y;
                        end
                    end
                end
            end

            WALK_RIGHT: begin
                if (move_tick) begin
                    state_nxt = IDLE;
                    if (can_go_right) begin
                        xpos_nxt = xpos + 12'd1;
                        if (on_step && ramp == game_pkg::RAMP_RISE) begin
                            ypos_nxt = ypos - game_pkg::RAMP_STEP_Y;
                        end else if (on_step && ramp == game_pkg::RAMP_FALL) begin
                            ypos_nxt = ypos + game_pkg::RAMP_STEP_Y;
                        end
                    end
                end
            end

            JUMP: begin
                if (fall_tick) begin
                    // Clamp at the peak once the next rise would reach it.
                    if (ypos <= peak_y + velocity) begin
                        ypos_nxt     = peak_y;
                        velocity_nxt = '0;
                        state_nxt    = FALL;
                    end else begin
                        ypos_nxt     = ypos - velocity;
                        velocity_nxt = velocity + 12'd1;
                    end
                end
            end

            FALL: begin
                if (ypos >= save_y) begin
                    state_nxt = IDLE;
                end else if (fall_tick) begin
                    velocity_nxt = velocity + 12'd1;
                    if (ypos + velocity >= save_y) begin
                        ypos_nxt  = save_y;
                        state_nxt = IDLE;
                    end else begin
                        ypos_nxt = ypos + velocity;
                    end
                end
            end

            CLIMB_UP: begin
                if (move_tick) begin
                    state_nxt = LADDER_IDLE;
                    if (ypos > climb_min) begin
                        ypos_nxt = ypos - 12'd1;
                        done_nxt = (ypos == climb_min + 12'd1);
                    end else begin
                        done_nxt = 1'b1;
                    end
                end
            end

            CLIMB_DOWN: begin
                if (move_tick) begin
                    state_nxt = LADDER_IDLE;
                    if (ypos < climb_max) begin
                        ypos_nxt = ypos + 12'd1;
                        done_nxt = (ypos + 12'd1 == climb_max);
                    end else begin
                        done_nxt = 1'b1;
                    end
                end
            end

            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

endmodule

// File: hdl/display_pkg.sv
package display_pkg;

    // Pixel coordinate wide enough for both screen axes.
    typedef logic [11:0] pos_t;

    // Visible area of the VGA mode.
    localparam pos_t HOR_PIXELS = 12'd800;
    localparam pos_t VER_PIXELS = 12'd600;

endpackage

// File: hdl/game_pkg.sv
package game_pkg;

    // Pacing counter sized for the longer of the two periods.
    typedef logic [7:0] pace_t;

    // Floor shape under the character.
    typedef logic [1:0] ramp_t;

    localparam ramp_t RAMP_FLAT = 2'd0;
    localparam ramp_t RAMP_RISE = 2'd1;
    localparam ramp_t RAMP_FALL = 2'd2;

    // Sprite size.
    localparam display_pkg::pos_t CHARACTER_WIDTH  = 12'd32;
    localparam display_pkg::pos_t CHARACTER_HEIGHT = 12'd64;

    // Clock cycles between pacing strobes.
    localparam pace_t MOVE_PERIOD = 8'd4;
    localparam pace_t FALL_PERIOD = 8'd6;

    localparam display_pkg::pos_t JUMP_HEIGHT = 12'd40;

    // The sprite stands on floor tiles 32 pixels tall.
    localparam display_pkg::pos_t GROUND_Y =
        display_pkg::VER_PIXELS - CHARACTER_HEIGHT - 12'd32;
    localparam display_pkg::pos_t UPPER_Y = GROUND_Y - 12'd160;

    // Upper platform span.
    localparam display_pkg::pos_t UPPER_X_MIN = 12'd64;
    localparam display_pkg::pos_t UPPER_X_MAX = 12'd352;

    // Ladder between the floor and the upper platform.
    localparam display_pkg::pos_t LADDER_X_MIN = 12'd192;
    localparam display_pkg::pos_t LADDER_X_MAX = 12'd208;

    // Ramp segment of the floor and its slope.
    localparam display_pkg::pos_t RAMP_X_MIN  = 12'd512;
    localparam display_pkg::pos_t RAMP_X_MAX  = 12'd767;
    localparam display_pkg::pos_t RAMP_STEP_X = 12'd64;
    localparam display_pkg::pos_t RAMP_STEP_Y = 12'd4;

    localparam display_pkg::pos_t START_X = 12'd1;

endpackage

// File: hdl/movement_top.sv
`timescale 1ns/1ps

module movement_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              left,
    input  logic              right,
    input  logic              jump,
    input  logic              up,
    input  logic              down,
    input  logic              start_game,
    input  logic              animation,
    output display_pkg::pos_t xpos,
    output display_pkg::pos_t ypos
);

    logic              restart;
    logic              move_tick;
    logic              fall_tick;
    logic              ladder;
    game_pkg::ramp_t   ramp;
    display_pkg::pos_t climb_min;
    display_pkg::pos_t climb_max;
    logic              end_of_platform;
    display_pkg::pos_t landing_y;

    step_timer step_timer_i (
        .clk       (clk),
        .rst       (rst),
        .restart   (restart),
        .move_tick (move_tick),
        .fall_tick (fall_tick)
    );

    // Map answers lag the position by one cycle.
    terrain_lookup terrain_lookup_i (
        .clk             (clk),
        .rst             (rst),
        .xpos            (xpos),
        .ypos            (ypos),
        .ladder          (ladder),
        .ramp            (ramp),
        .climb_min       (climb_min),
        .climb_max       (climb_max),
        .end_of_platform (end_of_platform),
        .landing_y       (landing_y)
    );

    character_motion character_motion_i (
        .clk             (clk),
        .rst             (rst),
        .left            (left),
        .right           (right),
        .jump            (jump),
        .up              (up),
        .down            (down),
        .start_game      (start_game),
        .animation       (animation),
        .move_tick       (move_tick),
        .fall_tick       (fall_tick),
        .ladder          (ladder),
        .ramp            (ramp),
        .climb_min       (climb_min),
        .climb_max       (climb_max),
        .end_of_platform (end_of_platform),
        .landing_y       (landing_y),
        .restart         (restart),
        .xpos            (xpos),
        .ypos            (ypos)
    );

endmodule

// File: hdl/step_timer.sv
`timescale 1ns/1ps

module step_timer (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic move_tick,
    output logic fall_tick
);

    game_pkg::pace_t move_cnt;
    game_pkg::pace_t fall_cnt;
    logic            move_wrap;
    logic            fall_wrap;

    assign move_wrap = (move_cnt == game_pkg::MOVE_PERIOD - game_pkg::pace_t'(1));
    assign fall_wrap = (fall_cnt == game_pkg::FALL_PERIOD - game_pkg::pace_t'(1));

    // Strobes are registered, so the first one lands a full period after restart.
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            move_cnt  <= '0;
            fall_cnt  <= '0;
            move_tick <= 1'b0;
            fall_tick <= 1'b0;
        end else begin
            if (move_wrap) begin
                move_cnt <= '0;
            end else begin
                move_cnt <= move_cnt + game_pkg::pace_t'(1);
            end

            if (fall_wrap) begin
                fall_cnt <= '0;
            end else begin
                fall_cnt <= fall_cnt + game_pkg::pace_t'(1);
            end

            move_tick <= move_wrap;
            fall_tick <= fall_wrap;
        end
    end

endmodule

// File: hdl/terrain_lookup.sv
`timescale 1ns/1ps

module terrain_lookup (
    input  logic              clk,
    input  logic              rst,
    input  display_pkg::pos_t xpos,
    input  display_pkg::pos_t ypos,
    output logic              ladder,
    output game_pkg::ramp_t   ramp,
    output display_pkg::pos_t climb_min,
    output display_pkg::pos_t climb_max,
    output logic              end_of_platform,
    output display_pkg::pos_t landing_y
);

    logic              on_ramp;
    logic              on_ladder;
    logic              off_upper;
    display_pkg::pos_t ramp_steps;

    assign on_ramp = (xpos >= game_pkg::RAMP_X_MIN) && (xpos <= game_pkg::RAMP_X_MAX);

    assign on_ladder = (xpos >= game_pkg::LADDER_X_MIN) &&
                       (xpos <= game_pkg::LADDER_X_MAX);

    assign off_upper = (xpos < game_pkg::UPPER_X_MIN) || (xpos > game_pkg::UPPER_X_MAX);

    // Ramp steps already climbed at this x.
    // A step is taken when leaving a multiple of RAMP_STEP_X.
    assign ramp_steps = (xpos - game_pkg::RAMP_X_MIN + game_pkg::RAMP_STEP_X - 12'd1) /
                        game_pkg::RAMP_STEP_X;

    always_ff @(posedge clk) begin
        if (rst) begin
            ladder          <= 1'b0;
            ramp            <= game_pkg::RAMP_FLAT;
            climb_min       <= game_pkg::UPPER_Y;
            climb_max       <= game_pkg::GROUND_Y;
            end_of_platform <= 1'b0;
            landing_y       <= game_pkg::GROUND_Y;
        end else begin
            ladder <= on_ladder;

            if (on_ramp) begin
                ramp <= game_pkg::RAMP_RISE;
            end else begin
                ramp <= game_pkg::RAMP_FLAT;
            end

            // The only ladder on this map spans floor to upper platform.
            climb_min <= game_pkg::UPPER_Y;
            climb_max <= game_pkg::GROUND_Y;

            end_of_platform <= (ypos == game_pkg::UPPER_Y) && off_upper;

            if (on_ramp) begin
                landing_y <= game_pkg::GROUND_Y - ramp_steps * game_pkg::RAMP_STEP_Y;
            end else begin
                landing_y <= game_pkg::GROUND_Y;
            end
        end
    end

endmodule

// File: movement_top.f
hdl/display_pkg.sv
hdl/game_pkg.sv
hdl/step_timer.sv
hdl/terrain_lookup.sv
hdl/character_motion.sv
hdl/movement_top.sv
verification/movement_top_tb.sv

// File: verification/movement_top_tb.sv
`timescale 1ns/1ps

module movement_top_tb;

    localparam int MAX_ROWS   = 16;
    localparam int STEP       = game_pkg::MOVE_PERIOD + 2;
    localparam int SETTLE     = 4;
    localparam int ROW_MARGIN = 200;

    localparam int SX         = game_pkg::START_X;
    localparam int GY         = game_pkg::GROUND_Y;
    localparam int UY         = game_pkg::UPPER_Y;
    localparam int LADDER_X   = (game_pkg::LADDER_X_MIN + game_pkg::LADDER_X_MAX) / 2;
    localparam int EDGE_X     = game_pkg::UPPER_X_MAX + 1;
    localparam int RAMP_X     = game_pkg::RAMP_X_MIN;
    localparam int RAMP_END_X = 720;

    // Key mask order is left, right, jump, up, down.
    localparam logic [4:0] KEY_NONE  = 5'b00000;
    localparam logic [4:0] KEY_LEFT  = 5'b10000;
    localparam logic [4:0] KEY_RIGHT = 5'b01000;
    localparam logic [4:0] KEY_JUMP  = 5'b00100;
    localparam logic [4:0] KEY_UP    = 5'b00010;
    localparam logic [4:0] KEY_DOWN  = 5'b00001;

    logic              clk;
    logic              rst;
    logic              left;
    logic              right;
    logic              jump;
    logic              up;
    logic              down;
    logic              start_game;
    logic              animation;
    display_pkg::pos_t xpos;
    display_pkg::pos_t ypos;

    string      row_name  [MAX_ROWS];
    logic [4:0] row_keys  [MAX_ROWS];
    logic       row_start [MAX_ROWS];
    logic       row_anim  [MAX_ROWS];
    int         row_hold  [MAX_ROWS];
    int         row_exp_x [MAX_ROWS];
    int         row_exp_y [MAX_ROWS];
    int         num_rows    = 0;
    int         cycle_count = 0;
    int         cycle_limit = 0;
    int         top_y       = 0;
    int         row;

    movement_top movement_top_i (
        .clk        (clk),
        .rst        (rst),
        .left       (left),
        .right      (right),
        .jump       (jump),
        .up         (up),
        .down       (down),
        .start_game (start_game),
        .animation  (animation),
        .xpos       (xpos),
        .ypos       (ypos)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: movement did not settle within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1, "run timed out");
        end
    end

    // Highest point reached during the current row.
    always @(negedge clk) begin
        if (int'(ypos) < top_y) begin
            top_y = int'(ypos);
        end
    end

    // Height gained walking right from x_from to x_to.
    // One lift per multiple of the step width on the ramp.
    function automatic int ramp_rise(input int x_from, input int x_to);
        int lift;
        int x;
        lift = 0;
        for (x = x_from; x < x_to; x++) begin
            if (x >= game_pkg::RAMP_X_MIN && x <= game_pkg::RAMP_X_MAX &&
                (x % game_pkg::RAMP_STEP_X) == 0) begin
                lift = lift + game_pkg::RAMP_STEP_Y;
            end
        end
        return lift;
    endfunction

    task automatic add_row(input string name, input logic [4:0] keys, input logic start,
                           input logic anim, input int hold, input int exp_x, input int exp_y);
        row_name[num_rows]  = name;
        row_keys[num_rows]  = keys;
        row_start[num_rows] = start;
        row_anim[num_rows]  = anim;
        row_hold[num_rows]  = hold;
        row_exp_x[num_rows] = exp_x;
        row_exp_y[num_rows] = exp_y;
        num_rows = num_rows + 1;
    endtask

    // Each walk or climb step takes STEP cycles with the key held.
    task automatic load_table();
        add_row("reset_idle", KEY_NONE, 1'b1, 1'b0, 2, SX, GY);
        add_row("no_start", KEY_RIGHT, 1'b0, 1'b0, 3 * STEP, SX, GY);
        add_row("animation_busy", KEY_RIGHT, 1'b1, 1'b1, 3 * STEP, SX, GY);
        add_row("left_wall", KEY_LEFT, 1'b1, 1'b0, 3 * STEP, SX, GY);
        add_row("walk_right", KEY_RIGHT, 1'b1, 1'b0, 10 * STEP, SX + 10, GY);
        add_row("jump", KEY_JUMP, 1'b1, 1'b0, 1, SX + 10, GY);
        add_row("walk_to_ladder", KEY_RIGHT, 1'b1, 1'b0, (LADDER_X - SX - 10) * STEP,
                LADDER_X, GY);
        add_row("climb_up", KEY_UP, 1'b1, 1'b0, 10 * STEP, LADDER_X, GY - 10);
        // Five extra steps press against the top of the ladder.
        add_row("climb_to_top", KEY_UP, 1'b1, 1'b0, (GY - 10 - UY + 5) * STEP, LADDER_X, UY);
        add_row("climb_down", KEY_DOWN, 1'b1, 1'b0, (GY - UY + 2) * STEP, LADDER_X, GY);
        add_row("climb_again", KEY_UP, 1'b1, 1'b0, (GY - UY) * STEP, LADDER_X, UY);
        add_row("walk_off_edge", KEY_RIGHT, 1'b1, 1'b0, (EDGE_X - LADDER_X) * STEP,
                EDGE_X, GY);
        add_row("walk_to_ramp", KEY_RIGHT, 1'b1, 1'b0, (RAMP_X - EDGE_X) * STEP, RAMP_X, GY);
        add_row("ramp_first_step", KEY_RIGHT, 1'b1, 1'b0, STEP, RAMP_X + 1,
                GY - ramp_rise(RAMP_X, RAMP_X + 1));
        add_row("ramp_cross", KEY_RIGHT, 1'b1, 1'b0, (RAMP_END_X - RAMP_X - 1) * STEP,
                RAMP_END_X, GY - ramp_rise(SX, RAMP_END_X));
    endtask

    task automatic check_value(input string name, input string what, input int expected,
                               input int actual);
        if (expected != actual) begin
            $display("error: %s %s expected %0d actual %0d", name, what, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch in test %s", name);
        end
    endtask

    task automatic drive_keys(input logic [4:0] keys);
        left  = keys[4];
        right = keys[3];
        jump  = keys[2];
        up    = keys[1];
        down  = keys[0];
    endtask

    // The controller is at rest once pacing stays in restart for several cycles.
    task automatic wait_for_rest();
        int quiet;
        quiet = 0;
        while (quiet < SETTLE) begin
            @(negedge clk);
            if (movement_top_i.restart) begin
                quiet = quiet + 1;
            end else begin
                quiet = 0;
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        start_game = 1'b0;
        animation  = 1'b0;
        drive_keys(KEY_NONE);

        load_table();
        cycle_limit = 16;
        for (row = 0; row < num_rows; row++) begin
            cycle_limit = cycle_limit + row_hold[row] + ROW_MARGIN;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (row = 0; row < num_rows; row++) begin
            @(negedge clk);
            top_y      = int'(ypos);
            start_game = row_start[row];
            animation  = row_anim[row];
            drive_keys(row_keys[row]);
            repeat (row_hold[row]) @(negedge clk);
            drive_keys(KEY_NONE);
            start_game = 1'b1;
            animation  = 1'b0;
            wait_for_rest();
            check_value(row_name[row], "xpos", row_exp_x[row], int'(xpos));
            check_value(row_name[row], "ypos", row_exp_y[row], int'(ypos));
            // A jump rises by the full jump height above its base before landing.
            if (row_keys[row] == KEY_JUMP) begin
                check_value(row_name[row], "peak ypos",
                            row_exp_y[row] - int'(game_pkg::JUMP_HEIGHT), top_y);
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
